/* all.f */
+incdir+logic
logic/rv_pkg.sv
logic/hazard_if.sv
logic/stage_reg.sv
logic/decoder.sv
logic/register_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/rv_pipeline.sv
verification/tb_checker.sv
verification/tb_top.sv

/* logic/alu.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu (
    input  logic [`RV_DATA_W-1:0] a,
    input  logic [`RV_DATA_W-1:0] b,
    input  rv_pkg::alu_op_t       op,
    output logic [`RV_DATA_W-1:0] result,
    output logic                  zero
);

    always_comb begin
        case (op)
            rv_pkg::ADD: result = a + b;
            rv_pkg::SUB: result = a - b;
            rv_pkg::AND: result = a & b;
            rv_pkg::OR:  result = a | b;
            rv_pkg::XOR: result = a ^ b;
            // signed compare, result is 0 or 1
            rv_pkg::SLT: result = {{(`RV_DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            default:     result = '0;
        endcase
    end

    // used by branches after a sub
    assign zero = (result == '0);

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module decoder (
    input  logic [`RV_DATA_W-1:0] instr,
    output rv_pkg::ctrl_t         ctrl,
    output logic [`RV_DATA_W-1:0] imm
);

    rv_pkg::opcode_t      opcode;
    logic [2:0]           funct3;
    logic [`RV_REG_W-1:0] rd;
    rv_pkg::alu_op_t      arith_op;
    logic                 arith_ok;

    assign opcode = rv_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];

    // funct3 to alu operation, shared by OP and OP_IMM
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            // bit 30 only means sub for register ops
            3'b000:  arith_op = (opcode == rv_pkg::OP && instr[30]) ? rv_pkg::SUB : rv_pkg::ADD;
            3'b010:  arith_op = rv_pkg::SLT;
            3'b100:  arith_op = rv_pkg::XOR;
            3'b110:  arith_op = rv_pkg::OR;
            3'b111:  arith_op = rv_pkg::AND;
            default: begin
                arith_op = rv_pkg::ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            rv_pkg::OP: begin
                if (arith_ok) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = arith_op;
                end
            end
            rv_pkg::OP_IMM: begin
                if (arith_ok) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.alu_op    = arith_op;
                    imm = {{(`RV_DATA_W-12){instr[31]}}, instr[31:20]};
                end
            end
            rv_pkg::LOAD: begin
                // lw only
                if (funct3 == 3'b010) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    imm = {{(`RV_DATA_W-12){instr[31]}}, instr[31:20]};
                end
            end
            rv_pkg::STORE: begin
                // sw only, address computed like a load
                if (funct3 == 3'b010) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    imm = {{(`RV_DATA_W-12){instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            rv_pkg::BRANCH: begin
                // beq and bne, compare by subtraction
                if (funct3[2:1] == 2'b00) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = rv_pkg::SUB;
                    imm = {{(`RV_DATA_W-13){instr[31]}}, instr[31], instr[7],
                           instr[30:25], instr[11:8], 1'b0};
                end
            end
            default: begin
                // anything else decodes to a bubble
                ctrl = '0;
            end
        endcase
        // writes to x0 are dropped here, never reach the trace
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

endmodule

/* logic/hazard_if.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

interface hazard_if (
    input logic CLK,
    input logic RESET_N
);
    // register numbers seen by the hazard logic
    logic [`RV_REG_W-1:0] rs1_id;
    logic [`RV_REG_W-1:0] rs2_id;
    logic [`RV_REG_W-1:0] rs1_ex;
    logic [`RV_REG_W-1:0] rs2_ex;
    logic [`RV_REG_W-1:0] rd_ex;
    logic [`RV_REG_W-1:0] rd_mem;
    logic [`RV_REG_W-1:0] rd_wb;
    logic                 mem_read_ex;
    logic                 reg_write_mem;
    logic                 reg_write_wb;
    // branch resolved in memory stage
    logic                 take_branch;

    // decisions back to the pipeline
    rv_pkg::fwd_sel_t fwd_a;
    rv_pkg::fwd_sel_t fwd_b;
    logic             stall;
    logic             flush;

    modport core (
        input  CLK, RESET_N,
        output rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, mem_read_ex,
        output rd_mem, reg_write_mem, rd_wb, reg_write_wb, take_branch,
        input  fwd_a, fwd_b, stall, flush
    );

    modport hazard (
        input  CLK, RESET_N,
        input  rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, mem_read_ex,
        input  rd_mem, reg_write_mem, rd_wb, reg_write_wb, take_branch,
        output fwd_a, fwd_b, stall, flush
    );
endinterface

/* logic/hazard_unit.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module hazard_unit (
    hazard_if.hazard hz
);

    logic load_use;

    // memory stage is younger, so it wins over write-back
    function automatic rv_pkg::fwd_sel_t pick_src(
        input logic [`RV_REG_W-1:0] rs,
        input logic [`RV_REG_W-1:0] rd_mem,
        input logic                 wr_mem,
        input logic [`RV_REG_W-1:0] rd_wb,
        input logic                 wr_wb
    );
        if (wr_mem && rd_mem != '0 && rd_mem == rs) begin
            return rv_pkg::FWD_MEM;
        end else if (wr_wb && rd_wb != '0 && rd_wb == rs) begin
            return rv_pkg::FWD_WB;
        end
        return rv_pkg::FWD_REG;
    endfunction

    assign hz.fwd_a = pick_src(hz.rs1_ex, hz.rd_mem, hz.reg_write_mem, hz.rd_wb, hz.reg_write_wb);
    assign hz.fwd_b = pick_src(hz.rs2_ex, hz.rd_mem, hz.reg_write_mem, hz.rd_wb, hz.reg_write_wb);

    // load in execute feeding the instruction in decode
    assign load_use = hz.mem_read_ex && hz.rd_ex != '0 &&
                      (hz.rd_ex == hz.rs1_id || hz.rd_ex == hz.rs2_id);

    // a taken branch squashes both, so no stall is needed then
    assign hz.stall = load_use && !hz.take_branch;
    assign hz.flush = hz.take_branch;

    // the bubble inserted in ID/EX must clear the hazard next cycle
    assert property (@(posedge hz.CLK) disable iff (!hz.RESET_N)
        hz.stall |-> hz.mem_read_ex ##1 !hz.stall);

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module register_file (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [`RV_REG_W-1:0]  rs1,
    input  logic [`RV_REG_W-1:0]  rs2,
    input  logic [`RV_REG_W-1:0]  rd,
    input  logic [`RV_DATA_W-1:0] wdata,
    input  logic                  we,
    output logic [`RV_DATA_W-1:0] rdata1,
    output logic [`RV_DATA_W-1:0] rdata2
);

    logic [`RV_DATA_W-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads zero
    // same-cycle write is seen by decode (write-first)
    assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

    // decoder strips x0 writes upstream, so none arrive from write-back
    assert property (@(posedge CLK) disable iff (!RESET_N) we |-> rd != '0);

endmodule

/* logic/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// one word, also the instruction width
`define RV_DATA_W 32

// word address width of each memory port
`define RV_ADDR_W 10

// register index width and number of registers
`define RV_REG_W 5
`define RV_NUM_REGS 32

`endif

/* logic/rv_pipeline.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_pipeline (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [`RV_DATA_W-1:0] idata,
    output logic [`RV_ADDR_W-1:0] iaddr,
    output logic [`RV_ADDR_W-1:0] daddr,
    input  logic [`RV_DATA_W-1:0] ddata_r,
    output logic [`RV_DATA_W-1:0] ddata_w,
    output logic                  mem_write,
    output logic                  mem_read,
    output logic [`RV_DATA_W-1:0] reg_write_data,
    output logic                  reg_write_enable,
    output logic [`RV_REG_W-1:0]  write_register
);

    logic [`RV_DATA_W-1:0] pc;
    logic [`RV_DATA_W-1:0] pc_next;
    rv_pkg::if_id_t        if_d, if_q;
    rv_pkg::id_ex_t        id_d, id_q;
    rv_pkg::ex_mem_t       ex_d, ex_q;
    rv_pkg::mem_wb_t       mem_d, mem_q;
    rv_pkg::ctrl_t         id_ctrl;
    logic [`RV_DATA_W-1:0] id_imm;
    logic [`RV_DATA_W-1:0] id_rdata1, id_rdata2;
    logic [`RV_DATA_W-1:0] op_a, op_b, alu_b;
    logic [`RV_DATA_W-1:0] ex_result;
    logic                  ex_zero;
    logic [`RV_DATA_W-1:0] wb_data;

    hazard_if hz (.CLK(CLK), .RESET_N(RESET_N));

    hazard_unit u_hazard (.hz(hz.hazard));

    // operand mux for the execute stage
    function automatic logic [`RV_DATA_W-1:0] fwd_mux(
        input rv_pkg::fwd_sel_t      sel,
        input logic [`RV_DATA_W-1:0] reg_val,
        input logic [`RV_DATA_W-1:0] mem_val,
        input logic [`RV_DATA_W-1:0] wb_val
    );
        case (sel)
            rv_pkg::FWD_MEM: return mem_val;
            rv_pkg::FWD_WB:  return wb_val;
            default:         return reg_val;
        endcase
    endfunction

    // fetch
    // pc frozen on load-use stall
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (!hz.stall) begin
            pc <= pc_next;
        end
    end

    assign pc_next = hz.take_branch ? ex_q.branch_target : pc + `RV_DATA_W'd4;
    assign iaddr   = pc[`RV_ADDR_W+1:2];
    assign if_d    = '{pc: pc, instr: idata};

    stage_reg #(.payload_t(rv_pkg::if_id_t)) u_if_id (
        .CLK(CLK), .RESET_N(RESET_N), .hold(hz.stall), .flush(hz.flush), .d(if_d), .q(if_q)
    );

    // decode
    decoder u_decoder (.instr(if_q.instr), .ctrl(id_ctrl), .imm(id_imm));

    register_file u_regs (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(if_q.instr[19:15]), .rs2(if_q.instr[24:20]),
        .rd(mem_q.rd), .wdata(wb_data), .we(mem_q.reg_write),
        .rdata1(id_rdata1), .rdata2(id_rdata2)
    );

    assign hz.rs1_id = if_q.instr[19:15];
    assign hz.rs2_id = if_q.instr[24:20];

    assign id_d = '{ctrl: id_ctrl, pc: if_q.pc, rdata1: id_rdata1, rdata2: id_rdata2,
                    imm: id_imm, rs1: if_q.instr[19:15], rs2: if_q.instr[24:20],
                    rd: if_q.instr[11:7]};

    // bubble into execute while decode waits on a load
    stage_reg #(.payload_t(rv_pkg::id_ex_t)) u_id_ex (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .flush(hz.stall | hz.flush),
        .d(id_d), .q(id_q)
    );

    // execute
    assign hz.rs1_ex      = id_q.rs1;
    assign hz.rs2_ex      = id_q.rs2;
    assign hz.rd_ex       = id_q.rd;
    assign hz.mem_read_ex = id_q.ctrl.mem_read;

    assign op_a  = fwd_mux(hz.fwd_a, id_q.rdata1, ex_q.alu_result, wb_data);
    assign op_b  = fwd_mux(hz.fwd_b, id_q.rdata2, ex_q.alu_result, wb_data);
    // store data keeps the forwarded rs2, not the immediate
    assign alu_b = id_q.ctrl.alu_src ? id_q.imm : op_b;

    alu u_alu (.a(op_a), .b(alu_b), .op(id_q.ctrl.alu_op), .result(ex_result), .zero(ex_zero));

    assign ex_d = '{ctrl: id_q.ctrl, alu_result: ex_result, zero: ex_zero, store_data: op_b,
                    branch_target: id_q.pc + id_q.imm, rd: id_q.rd};

    stage_reg #(.payload_t(rv_pkg::ex_mem_t)) u_ex_mem (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .flush(hz.flush), .d(ex_d), .q(ex_q)
    );

    // memory
    assign daddr     = ex_q.alu_result[`RV_ADDR_W+1:2];
    assign ddata_w   = ex_q.store_data;
    assign mem_write = ex_q.ctrl.mem_write;
    assign mem_read  = ex_q.ctrl.mem_read;

    // beq on zero, bne on nonzero
    assign hz.take_branch   = ex_q.ctrl.branch && (ex_q.zero ^ ex_q.ctrl.branch_ne);
    assign hz.rd_mem        = ex_q.rd;
    assign hz.reg_write_mem = ex_q.ctrl.reg_write;

    assign mem_d = '{reg_write: ex_q.ctrl.reg_write, mem_read: ex_q.ctrl.mem_read,
                     alu_result: ex_q.alu_result, load_data: ddata_r, rd: ex_q.rd};

    stage_reg #(.payload_t(rv_pkg::mem_wb_t)) u_mem_wb (
        .CLK(CLK), .RESET_N(RESET_N), .hold(1'b0), .flush(1'b0), .d(mem_d), .q(mem_q)
    );

    // write-back
    assign wb_data         = mem_q.mem_read ? mem_q.load_data : mem_q.alu_result;
    assign hz.rd_wb        = mem_q.rd;
    assign hz.reg_write_wb = mem_q.reg_write;

    // trace outputs
    assign reg_write_enable = mem_q.reg_write;
    assign write_register   = mem_q.rd;
    assign reg_write_data   = wb_data;

    // a branch flush must never coincide with a held fetch
    assert property (@(posedge CLK) disable iff (!RESET_N) !(hz.stall && hz.flush));

endmodule

/* logic/rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5
    } alu_op_t;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_t;

    // all zero means bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        // funct3[0], set for bne
        logic    branch_ne;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_DATA_W-1:0] pc;
        logic [`RV_DATA_W-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`RV_DATA_W-1:0] pc;
        logic [`RV_DATA_W-1:0] rdata1;
        logic [`RV_DATA_W-1:0] rdata2;
        logic [`RV_DATA_W-1:0] imm;
        logic [`RV_REG_W-1:0]  rs1;
        logic [`RV_REG_W-1:0]  rs2;
        logic [`RV_REG_W-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`RV_DATA_W-1:0] alu_result;
        logic                  zero;
        logic [`RV_DATA_W-1:0] store_data;
        logic [`RV_DATA_W-1:0] branch_target;
        logic [`RV_REG_W-1:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic [`RV_DATA_W-1:0] alu_result;
        logic [`RV_DATA_W-1:0] load_data;
        logic [`RV_REG_W-1:0]  rd;
    } mem_wb_t;

endpackage

/* logic/stage_reg.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module stage_reg #(
    parameter type payload_t = logic [`RV_DATA_W-1:0]
) (
    input  logic     CLK,
    input  logic     RESET_N,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload is a bubble
    // flush wins over hold
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

/* verification/tb_checker.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_checker #(
    parameter int PROG_LEN = 48
) (
    input logic                  CLK,
    input logic                  RESET_N,
    input logic                  reg_write_enable,
    input logic [`RV_REG_W-1:0]  write_register,
    input logic [`RV_DATA_W-1:0] reg_write_data,
    input logic                  mem_write,
    input logic                  mem_read,
    input logic [`RV_ADDR_W-1:0] daddr,
    input logic [`RV_DATA_W-1:0] ddata_w
);

    logic [31:0] prog  [PROG_LEN];
    logic [31:0] mregs [32];
    // offsets 0 to 60 only
    logic [31:0] mmem  [16];

    // expected architectural effects, program order
    int                    exp_wr_rd  [$];
    logic [31:0]           exp_wr_val [$];
    logic [`RV_ADDR_W-1:0] exp_st_adr [$];
    logic [31:0]           exp_st_dat [$];
    logic [`RV_ADDR_W-1:0] exp_ld_adr [$];

    bit    active       = 1'b0;
    int    edge_cnt     = 0;
    int    test_num     = 0;
    string test_name    = "";
    int    test_errors  = 0;
    int    writes_seen  = 0;
    int    stores_seen  = 0;
    int    loads_seen   = 0;
    int    total_errors = 0;
    int    total_checks = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;

    task automatic load_instr(input int idx, input logic [31:0] w);
        prog[idx] = w;
    endtask

    task automatic load_data(input int idx, input logic [31:0] w);
        mmem[idx] = w;
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // x0 never changes and never shows on the trace
    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 5'd0) begin
            mregs[rd] = val;
            exp_wr_rd.push_back(rd);
            exp_wr_val.push_back(val);
        end
    endtask

    // one instruction per step, no timing
    task automatic run_model();
        int          pc;
        int          cur;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = 32'd0;
        end
        pc = 0;
        while (pc < PROG_LEN) begin
            cur   = pc;
            ins   = prog[cur];
            a     = mregs[ins[19:15]];
            b     = mregs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            pc    = cur + 1;
            case (ins[6:0])
                7'b0110011: write_reg(ins[11:7], alu_model(ins[14:12], ins[30], a, b));
                7'b0010011: write_reg(ins[11:7], alu_model(ins[14:12], 1'b0, a, imm_i));
                7'b0000011: begin
                    addr = a + imm_i;
                    exp_ld_adr.push_back(addr[`RV_ADDR_W+1:2]);
                    write_reg(ins[11:7], mmem[addr[5:2]]);
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    mmem[addr[5:2]] = b;
                    exp_st_adr.push_back(addr[`RV_ADDR_W+1:2]);
                    exp_st_dat.push_back(b);
                end
                7'b1100011: begin
                    // funct3 bit 0 turns beq into bne
                    if ((a == b) ^ ins[12]) begin
                        pc = cur + int'($signed(imm_b) >>> 2);
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic begin_test(input int id, input string name);
        exp_wr_rd.delete();
        exp_wr_val.delete();
        exp_st_adr.delete();
        exp_st_dat.delete();
        exp_ld_adr.delete();
        test_num    = id;
        test_name   = name;
        test_errors = 0;
        writes_seen = 0;
        stores_seen = 0;
        loads_seen  = 0;
        run_model();
        active = 1'b1;
    endtask

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_write();
        int          exp_rd;
        logic [31:0] exp_val;
        total_checks++;
        if (exp_wr_rd.size() == 0) begin
            $display("%0t ns: write-back to x%0d that the model never makes",
                     $time, write_register);
            note_error();
        end else begin
            exp_rd  = exp_wr_rd.pop_front();
            exp_val = exp_wr_val.pop_front();
            writes_seen++;
            if (write_register != exp_rd || reg_write_data !== exp_val) begin
                $display("mismatch at %0t ns: write-back x%0d = %h, expected x%0d = %h",
                         $time, write_register, reg_write_data, exp_rd, exp_val);
                note_error();
            end
        end
    endtask

    task automatic check_store();
        logic [`RV_ADDR_W-1:0] exp_adr;
        logic [31:0]           exp_dat;
        total_checks++;
        if (exp_st_adr.size() == 0) begin
            $display("%0t ns: store to word %0d that the model never makes", $time, daddr);
            note_error();
        end else begin
            exp_adr = exp_st_adr.pop_front();
            exp_dat = exp_st_dat.pop_front();
            stores_seen++;
            if (daddr != exp_adr || ddata_w !== exp_dat) begin
                $display("mismatch at %0t ns: store word %0d = %h, expected word %0d = %h",
                         $time, daddr, ddata_w, exp_adr, exp_dat);
                note_error();
            end
        end
    endtask

    // one read strobe per executed lw
    task automatic check_load();
        logic [`RV_ADDR_W-1:0] exp_adr;
        total_checks++;
        if (exp_ld_adr.size() == 0) begin
            $display("%0t ns: load from word %0d that the model never makes", $time, daddr);
            note_error();
        end else begin
            exp_adr = exp_ld_adr.pop_front();
            loads_seen++;
            if (daddr != exp_adr) begin
                $display("mismatch at %0t ns: load word %0d, expected word %0d",
                         $time, daddr, exp_adr);
                note_error();
            end
        end
    endtask

    // edges since reset release
    always @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    // outputs settle by mid-cycle
    always @(negedge CLK) begin
        if (active) begin
            // first fetch at edge 1, its write-back follows edge 4
            if (edge_cnt <= 3 && (reg_write_enable || mem_write || mem_read)) begin
                $display("%0t ns: strobe high %0d cycles after reset, before any instruction",
                         $time, edge_cnt);
                note_error();
            end
            if (edge_cnt == 4 && !reg_write_enable) begin
                $display("%0t ns: first write-back missing four cycles after the first fetch",
                         $time);
                note_error();
            end
            if (reg_write_enable) begin
                check_write();
            end
            if (mem_write) begin
                check_store();
            end
            if (mem_read) begin
                check_load();
            end
        end
    end

    task automatic end_test();
        active = 1'b0;
        if (exp_wr_rd.size() != 0 || exp_st_adr.size() != 0 || exp_ld_adr.size() != 0) begin
            $display("test %0d left %0d write-backs, %0d stores and %0d loads of the model unseen",
                     test_num, exp_wr_rd.size(), exp_st_adr.size(), exp_ld_adr.size());
            note_error();
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d write-backs, %0d stores, %0d loads, %0d errors",
                 test_num, test_name, (test_errors == 0) ? "PASS" : "FAIL", writes_seen,
                 stores_seen, loads_seen, test_errors);
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_checks,
                 total_errors);
    endtask

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_top;

    localparam int PROG_LEN    = 48;
    localparam int NUM_TESTS   = 4;
    // program length with headroom for stalls and branch refills
    localparam int CYCLE_LIMIT = 4 * PROG_LEN + 40;
    // fetch reaches this word only after the whole program has drained
    localparam int END_WORD    = PROG_LEN + 8;
    localparam int MEM_WORDS   = 1 << `RV_ADDR_W;

    logic                  CLK;
    logic                  RESET_N;
    logic [`RV_DATA_W-1:0] idata;
    logic [`RV_ADDR_W-1:0] iaddr;
    logic [`RV_ADDR_W-1:0] daddr;
    logic [`RV_DATA_W-1:0] ddata_r;
    logic [`RV_DATA_W-1:0] ddata_w;
    logic                  mem_write;
    logic                  mem_read;
    logic [`RV_DATA_W-1:0] reg_write_data;
    logic                  reg_write_enable;
    logic [`RV_REG_W-1:0]  write_register;

    logic [`RV_DATA_W-1:0] imem [MEM_WORDS];
    logic [`RV_DATA_W-1:0] dmem [MEM_WORDS];
    integer                seed;

    rv_pipeline DUT (
        .CLK(CLK), .RESET_N(RESET_N),
        .idata(idata), .iaddr(iaddr),
        .daddr(daddr), .ddata_r(ddata_r), .ddata_w(ddata_w),
        .mem_write(mem_write), .mem_read(mem_read),
        .reg_write_data(reg_write_data), .reg_write_enable(reg_write_enable),
        .write_register(write_register)
    );

    tb_checker #(.PROG_LEN(PROG_LEN)) chk (
        .CLK(CLK), .RESET_N(RESET_N),
        .reg_write_enable(reg_write_enable), .write_register(write_register),
        .reg_write_data(reg_write_data),
        .mem_write(mem_write), .mem_read(mem_read), .daddr(daddr), .ddata_w(ddata_w)
    );

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic int roll(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // instruction encoders, standard RV32I formats
    function automatic logic [31:0] alu_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input int rs1,
                                             input logic [2:0] f3, input int rd,
                                             input logic [6:0] opc);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    // sw always uses base x0
    function automatic logic [31:0] store_word(input logic [11:0] imm, input int rs2);
        return {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input int rs1,
                                                input int rs2, input logic ne);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, imm[4:1], imm[11],
                7'b1100011};
    endfunction

    // 0 reg alu, 1 addi, 2 lw, 3 sw, 4 branch
    function automatic int pick_kind(input int test_id, input int pct);
        // percent for reg alu, addi, lw and sw, branches get the rest
        int weight [4];
        case (test_id)
            1:       weight = '{45, 55, 0, 0};
            2:       weight = '{15, 15, 35, 35};
            3:       weight = '{25, 25, 0, 15};
            default: weight = '{25, 25, 15, 15};
        endcase
        if (pct < weight[0]) return 0;
        if (pct < weight[0] + weight[1]) return 1;
        if (pct < weight[0] + weight[1] + weight[2]) return 2;
        if (pct < weight[0] + weight[1] + weight[2] + weight[3]) return 3;
        return 4;
    endfunction

    task automatic write_program(input int test_id);
        int          kind;
        int          sel;
        int          rd;
        int          rs1;
        int          rs2;
        int          imm;
        int          last_rd;
        int          last_off;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] w;
        last_rd  = 1;
        last_off = 0;
        // x0 no-ops past the program, imm carries the address
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = {2'b00, a[9:0], 13'd0, 7'b0010011};
            dmem[a] = {a[9:0], 6'h2a, ~a[9:0], 6'h15};
        end
        for (int a = 0; a < 16; a++) begin
            chk.load_data(a, dmem[a]);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rd   = roll(8);
            // half the sources chain on the previous result
            rs1  = (roll(2) == 0) ? last_rd : roll(8);
            rs2  = roll(8);
            kind = pick_kind(test_id, roll(100));
            // first write-back timing needs a plain addi to a real register
            if (i == 0) begin
                kind = 1;
                rd   = 1 + roll(7);
                rs1  = 0;
            end
            case (kind)
                0: begin
                    sel = roll(6);
                    f7  = (sel == 1) ? 7'h20 : 7'h00;
                    case (sel)
                        0, 1:    f3 = 3'b000;
                        2:       f3 = 3'b111;
                        3:       f3 = 3'b110;
                        4:       f3 = 3'b100;
                        default: f3 = 3'b010;
                    endcase
                    w = alu_word(f7, f3, rd, rs1, rs2);
                    last_rd = rd;
                end
                1: begin
                    // full signed range, negatives feed slt
                    imm = roll(4096);
                    w = imm_word(imm[11:0], rs1, 3'b000, rd, 7'b0010011);
                    last_rd = rd;
                end
                2: begin
                    imm = (roll(2) == 0) ? last_off : roll(16) * 4;
                    w = imm_word(imm[11:0], 0, 3'b010, rd, 7'b0000011);
                    last_rd = rd;
                end
                3: begin
                    imm = roll(16) * 4;
                    // data register biased towards the last result
                    w = store_word(imm[11:0], rs1);
                    last_off = imm;
                end
                default: begin
                    imm = (roll(2) == 0) ? 8 : 12;
                    // small register set so operands often match
                    w = branch_word(imm[12:0], roll(4), roll(4), roll(2));
                end
            endcase
            imem[i] = w;
            chk.load_instr(i, w);
        end
    endtask

    task automatic start_test(input int test_id, input string name);
        RESET_N = 1'b0;
        write_program(test_id);
        chk.begin_test(test_id, name);
        repeat (8) @(negedge CLK);
        RESET_N = 1'b1;
    endtask

    task automatic wait_for_end(output bit timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while (iaddr != END_WORD && !timed_out) begin
            @(negedge CLK);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        bit    timed_out;
        int    stop_test;
        string names [NUM_TESTS];
        names[0]  = "alu chains";
        names[1]  = "store and load";
        names[2]  = "branches";
        names[3]  = "mixed";
        seed      = 32'ha69b_6c3f;
        RESET_N   = 1'b0;
        timed_out = 1'b0;
        stop_test = 0;
        for (int t = 1; t <= NUM_TESTS && !timed_out; t++) begin
            start_test(t, names[t-1]);
            wait_for_end(timed_out);
            if (timed_out) begin
                stop_test = t;
            end else begin
                chk.end_test();
            end
        end
        if (timed_out) begin
            $display("timeout: test %0d did not run past its program within %0d cycles",
                     stop_test, CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
        end else begin
            chk.report();
            if (chk.total_errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
        end
        $finish;
    end

endmodule
